//--- logic/chan_acc_pkg.sv
package chan_acc_pkg;

  ////////////////////////////////////////////////////////////
  // Sizes of the stage

  localparam int DATA_WIDTH  = 32;
  localparam int IMAGE_WIDTH = 4;
  localparam int IMAGE_SIZE  = IMAGE_WIDTH * IMAGE_WIDTH;
  localparam int CHANNEL_NUM = 4;
  localparam int BANK_NUM    = 2;

  ////////////////////////////////////////////////////////////
  // Word and index types

  typedef logic [DATA_WIDTH-1:0]          pixel_t;
  typedef logic [$clog2(IMAGE_SIZE)-1:0]  pix_addr_t;
  // Bank bit on top of the pixel index
  typedef logic [$clog2(BANK_NUM)+$clog2(IMAGE_SIZE)-1:0] mem_addr_t;
  typedef logic [$clog2(CHANNEL_NUM)-1:0] chan_t;

  // State machines
  typedef enum logic [2:0] {
    ACC_IDLE, ACC_READ, ACC_ADD, ACC_WRITE, ACC_WAIT_BANK
  } acc_state_t;

  typedef enum logic [1:0] {
    DRN_IDLE, DRN_READ, DRN_SEND
  } drain_state_t;

endpackage

//--- logic/chan_acc_top.sv
`timescale 1ns/1ps

module chan_acc_top import chan_acc_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   valid_in,
  input  pixel_t pxl_in,
  output logic   ready_in,
  output logic   valid_out,
  output pixel_t pxl_out,
  input  logic   ready_out
);

  // Bank handover between the two peers
  logic bank_full;
  logic full_bank;
  logic bank_free;

  psum_mem_if acc_mem ();
  psum_mem_if drn_mem ();
  psum_mem_if buf_mem ();

  ////////////////////////////////////////////////////////////
  // Peers

  channel_accumulator inst_acc (
    .clk      (clk      ),
    .reset    (reset    ),
    .valid_in (valid_in ),
    .pxl_in   (pxl_in   ),
    .ready_in (ready_in ),
    .bank_free(bank_free),
    .bank_full(bank_full),
    .full_bank(full_bank),
    .mem      (acc_mem  )
  );

  result_drain inst_drain (
    .clk      (clk      ),
    .reset    (reset    ),
    .bank_full(bank_full),
    .full_bank(full_bank),
    .bank_free(bank_free),
    .valid_out(valid_out),
    .pxl_out  (pxl_out  ),
    .ready_out(ready_out),
    .mem      (drn_mem  )
  );

  ////////////////////////////////////////////////////////////
  // Shared buffer

  psum_arbiter inst_arb (
    .clk    (clk    ),
    .reset  (reset  ),
    .acc_mem(acc_mem),
    .drn_mem(drn_mem),
    .buf_mem(buf_mem)
  );

  psum_buffer inst_buf (
    .clk  (clk    ),
    .reset(reset  ),
    .mem  (buf_mem)
  );

endmodule

//--- logic/channel_accumulator.sv
`timescale 1ns/1ps

module channel_accumulator import chan_acc_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          valid_in,
  input  pixel_t        pxl_in,
  output logic          ready_in,
  input  logic          bank_free,
  output logic          bank_full,
  output logic          full_bank,
  psum_mem_if.requester mem
);

  acc_state_t          state;
  pix_addr_t           pix_cnt;
  chan_t               chan_cnt;
  logic                bank;
  // Next bank the drain will release
  logic                free_ptr;
  logic [BANK_NUM-1:0] pending;
  logic                req;
  pixel_t              pixel;
  pixel_t              sum;
  logic                last_pix;
  logic                last_chan;

  assign last_pix  = (pix_cnt == pix_addr_t'(IMAGE_SIZE - 1));
  assign last_chan = (chan_cnt == chan_t'(CHANNEL_NUM - 1));

  assign ready_in  = (state == ACC_IDLE);

  assign mem.req   = req;
  assign mem.we    = (state == ACC_WRITE);
  assign mem.addr  = {bank, pix_cnt};
  assign mem.wdata = sum;

  ////////////////////////////////////////////////////////////
  // Pixel and partial sum

  always_ff @(posedge clk) begin
    if (valid_in && ready_in) begin
      pixel <= pxl_in;
      // First channel starts the sum from zero
      if (chan_cnt == '0) begin
        sum <= pxl_in;
      end
    end else if (state == ACC_READ && req && mem.ack) begin
      sum <= mem.rdata;
    end else if (state == ACC_ADD) begin
      sum <= sum + pixel;
    end
  end

  ////////////////////////////////////////////////////////////
  // Control FSM and bank bookkeeping

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ACC_WAIT_BANK;
      req       <= 1'b0;
      pix_cnt   <= '0;
      chan_cnt  <= '0;
      bank      <= 1'b0;
      free_ptr  <= 1'b0;
      pending   <= '0;
      bank_full <= 1'b0;
      full_bank <= 1'b0;
    end else begin
      bank_full <= 1'b0;
      if (bank_free) begin
        pending[free_ptr] <= 1'b0;
        free_ptr          <= ~free_ptr;
      end
      case (state)
        ACC_IDLE: begin
          if (valid_in) begin
            state <= (chan_cnt == '0) ? ACC_WRITE : ACC_READ;
          end
        end
        ACC_READ: begin
          if (req && mem.ack) begin
            req   <= 1'b0;
            state <= ACC_ADD;
          end else if (!req && !mem.ack) begin
            req <= 1'b1;
          end
        end
        ACC_ADD: begin
          state <= ACC_WRITE;
        end
        ACC_WRITE: begin
          if (req && mem.ack) begin
            req     <= 1'b0;
            state   <= ACC_IDLE;
            pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
            if (last_pix) begin
              chan_cnt <= last_chan ? '0 : chan_cnt + 1'b1;
              if (last_chan) begin
                // Frame done so the bank goes to the drain
                bank_full     <= 1'b1;
                full_bank     <= bank;
                pending[bank] <= 1'b1;
                bank          <= ~bank;
                state         <= ACC_WAIT_BANK;
              end
            end
          end else if (!req && !mem.ack) begin
            req <= 1'b1;
          end
        end
        ACC_WAIT_BANK: begin
          if (!pending[bank]) begin
            state <= ACC_IDLE;
          end
        end
        default: state <= ACC_WAIT_BANK;
      endcase
    end
  end

endmodule

//--- logic/psum_arbiter.sv
`timescale 1ns/1ps

module psum_arbiter (
  input logic           clk,
  input logic           reset,
  psum_mem_if.responder acc_mem,
  psum_mem_if.responder drn_mem,
  psum_mem_if.requester buf_mem
);

  // Grant is 0 for the accumulator and 1 for the drain
  logic grant;
  logic busy;
  logic last;
  logic win_req;
  logic pick;

  assign win_req = grant ? drn_mem.req : acc_mem.req;

  // On a tie the side that lost last time goes first
  assign pick = (acc_mem.req && drn_mem.req) ? ~last : drn_mem.req;

  ////////////////////////////////////////////////////////////
  // Grant tracking

  always_ff @(posedge clk) begin
    if (reset) begin
      grant <= 1'b0;
      busy  <= 1'b0;
      last  <= 1'b1;
    end else if (!busy) begin
      if (acc_mem.req || drn_mem.req) begin
        grant <= pick;
        busy  <= 1'b1;
      end
    end else if (!win_req && !buf_mem.ack) begin
      // Exchange fully closed on both sides
      busy <= 1'b0;
      last <= grant;
    end
  end

  ////////////////////////////////////////////////////////////
  // Request path toward the buffer

  assign buf_mem.req   = busy && win_req;
  assign buf_mem.we    = grant ? drn_mem.we    : acc_mem.we;
  assign buf_mem.addr  = grant ? drn_mem.addr  : acc_mem.addr;
  assign buf_mem.wdata = grant ? drn_mem.wdata : acc_mem.wdata;

  ////////////////////////////////////////////////////////////
  // Response path, winner only

  assign acc_mem.ack   = busy && !grant && buf_mem.ack;
  assign drn_mem.ack   = busy && grant && buf_mem.ack;
  assign acc_mem.rdata = (busy && !grant) ? buf_mem.rdata : '0;
  assign drn_mem.rdata = (busy && grant) ? buf_mem.rdata : '0;

endmodule

//--- logic/psum_buffer.sv
`timescale 1ns/1ps

module psum_buffer import chan_acc_pkg::*; (
  input logic           clk,
  input logic           reset,
  psum_mem_if.responder mem
);

  pixel_t    ram [BANK_NUM][IMAGE_SIZE];
  pixel_t    rdata;
  logic      ack;
  logic      bank;
  pix_addr_t pix;
  logic      start;

  // Bank bit sits above the pixel index
  assign bank  = mem.addr[$bits(mem_addr_t)-1];
  assign pix   = mem.addr[$bits(pix_addr_t)-1:0];

  // New exchange seen, ack not yet raised
  assign start = mem.req && !ack;

  assign mem.ack   = ack;
  assign mem.rdata = rdata;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else if (start) begin
      ack <= 1'b1;
    end else if (!mem.req) begin
      ack <= 1'b0;
    end
  end

  // Access happens on the edge that raises ack
  always_ff @(posedge clk) begin
    if (start) begin
      if (mem.we) begin
        ram[bank][pix] <= mem.wdata;
      end
      rdata <= ram[bank][pix];
    end
  end

endmodule

//--- logic/psum_mem_if.sv
`timescale 1ns/1ps

// One requester's four-phase access to the partial-sum buffer
interface psum_mem_if import chan_acc_pkg::*; ();

  logic      req;
  logic      ack;
  logic      we;
  mem_addr_t addr;
  pixel_t    wdata;
  // Valid while ack is high on a read
  pixel_t    rdata;

  modport requester (
    output req, we, addr, wdata,
    input  ack, rdata
  );

  modport responder (
    input  req, we, addr, wdata,
    output ack, rdata
  );

endinterface

//--- logic/result_drain.sv
`timescale 1ns/1ps

module result_drain import chan_acc_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  input  logic          bank_full,
  input  logic          full_bank,
  output logic          bank_free,
  output logic          valid_out,
  output pixel_t        pxl_out,
  input  logic          ready_out,
  psum_mem_if.requester mem
);

  drain_state_t state;
  // Finished banks with the oldest in slot 0
  logic         queue [BANK_NUM];
  logic [1:0]   count;
  logic         slot;
  pix_addr_t    pix_cnt;
  logic         req;
  logic         last_pix;
  logic         pop;

  assign last_pix  = (pix_cnt == pix_addr_t'(IMAGE_SIZE - 1));
  assign pop       = (state == DRN_SEND) && ready_out && last_pix;

  // Push goes behind whatever stays after a pop
  assign slot      = pop ? (count == 2'd2) : (count == 2'd1);

  assign valid_out = (state == DRN_SEND);

  assign mem.req   = req;
  assign mem.we    = 1'b0;
  assign mem.addr  = {queue[0], pix_cnt};
  assign mem.wdata = '0;

  always_ff @(posedge clk) begin
    if (pop) begin
      queue[0] <= queue[1];
    end
    if (bank_full) begin
      queue[slot] <= full_bank;
    end
    if (state == DRN_READ && req && mem.ack) begin
      pxl_out <= mem.rdata;
    end
  end

  ////////////////////////////////////////////////////////////
  // Read one word and hold it until it is taken

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= DRN_IDLE;
      req       <= 1'b0;
      count     <= 2'd0;
      pix_cnt   <= '0;
      bank_free <= 1'b0;
    end else begin
      bank_free <= pop;
      count     <= count + {1'b0, bank_full} - {1'b0, pop};
      case (state)
        DRN_IDLE: begin
          if (count != 2'd0 && !mem.ack) begin
            req   <= 1'b1;
            state <= DRN_READ;
          end
        end
        DRN_READ: begin
          if (req && mem.ack) begin
            req   <= 1'b0;
            state <= DRN_SEND;
          end
        end
        DRN_SEND: begin
          if (ready_out) begin
            pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
            state   <= DRN_IDLE;
          end
        end
        default: state <= DRN_IDLE;
      endcase
    end
  end

endmodule

//--- sim/chan_acc_tb.sv
`timescale 1ns/1ps

module chan_acc_tb import chan_acc_pkg::*; ();

  localparam int FRAME_PIXELS = CHANNEL_NUM * IMAGE_SIZE;

  logic        clk;
  logic        reset;
  logic        valid_in;
  pixel_t      pxl_in;
  logic        ready_in;
  logic        valid_out;
  pixel_t      pxl_out;
  logic        ready_out;

  // 0 holds ready_out low, 1 mostly high, 2 mostly low
  int          stall_mode;
  logic [31:0] rnd_in;
  logic [31:0] rnd_out;
  pixel_t      exp_q[$];
  pixel_t      exp_val;
  pixel_t      held_val;
  logic        held;
  int          in_count;
  int          out_count;
  int          frames;
  int          mismatch_errors;
  int          other_errors;

  chan_acc_top dut_i (
    .clk      (clk      ),
    .reset    (reset    ),
    .valid_in (valid_in ),
    .pxl_in   (pxl_in   ),
    .ready_in (ready_in ),
    .valid_out(valid_out),
    .pxl_out  (pxl_out  ),
    .ready_out(ready_out)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Output back-pressure

  initial begin
    ready_out = 1'b0;
    rnd_out   = xorshift(32'd54);
    forever begin
      @(negedge clk);
      rnd_out = xorshift(rnd_out);
      case (stall_mode)
        0:       ready_out = 1'b0;
        1:       ready_out = (rnd_out[1:0] != 2'd0);
        default: ready_out = (rnd_out[1:0] == 2'd0);
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Monitor and checks on every rising edge

  always @(posedge clk) begin
    if (!reset) begin
      if (valid_in && ready_in) begin
        in_count++;
      end
      if (in_count < FRAME_PIXELS) begin
        assert (!valid_out) else begin
          other_errors++;
          $display("valid_out went high before the first frame was complete");
        end
      end
      if (held) begin
        assert (valid_out && pxl_out === held_val) else begin
          mismatch_errors++;
          $display("Mismatch pxl_out: held %h changed to %h, valid_out %h",
                   held_val, pxl_out, valid_out);
        end
      end
      if (valid_out && ready_out) begin
        assert (exp_q.size() != 0) else begin
          other_errors++;
          $display("An output pixel arrived when none was expected");
        end
        if (exp_q.size() != 0) begin
          exp_val = exp_q.pop_front();
          assert (pxl_out === exp_val) else begin
            mismatch_errors++;
            $display("Mismatch pxl_out: got %h expected %h at output %0d",
                     pxl_out, exp_val, out_count);
          end
        end
        out_count++;
      end
      held     = valid_out && !ready_out;
      held_val = pxl_out;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks

  // Builds one frame, queues its sums, then offers it pixel by pixel
  task automatic feed_frame(input bit gaps);
    pixel_t planes [FRAME_PIXELS];
    pixel_t sums [IMAGE_SIZE];
    int     wait_cnt;
    for (int p = 0; p < IMAGE_SIZE; p++) begin
      sums[p] = '0;
    end
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      rnd_in    = xorshift(rnd_in);
      planes[i] = rnd_in;
      sums[i % IMAGE_SIZE] = sums[i % IMAGE_SIZE] + rnd_in;
    end
    for (int p = 0; p < IMAGE_SIZE; p++) begin
      exp_q.push_back(sums[p]);
    end
    frames++;
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      if (gaps) begin
        rnd_in   = xorshift(rnd_in);
        valid_in = 1'b0;
        repeat (rnd_in[1:0]) @(negedge clk);
      end
      valid_in = 1'b1;
      pxl_in   = planes[i];
      wait_cnt = 0;
      while (!ready_in && wait_cnt < 200) begin
        @(negedge clk);
        wait_cnt++;
      end
      if (!ready_in) begin
        other_errors++;
        $display("Timeout: input pixel %0d of frame %0d was never accepted", i, frames);
      end
      @(negedge clk);
    end
    valid_in = 1'b0;
  endtask

  task automatic wait_ready_in(input int limit);
    int cnt;
    cnt = 0;
    while (!ready_in && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (!ready_in) begin
      other_errors++;
      $display("Timeout: ready_in did not go high");
    end
  endtask

  task automatic wait_drained(input int limit);
    int cnt;
    cnt = 0;
    while (exp_q.size() != 0 && cnt < limit) begin
      @(negedge clk);
      cnt++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Timeout: %0d expected output pixels never came out", exp_q.size());
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence

  initial begin
    reset           = 1'b1;
    valid_in        = 1'b0;
    pxl_in          = '0;
    stall_mode      = 1;
    rnd_in          = 32'd54;
    held            = 1'b0;
    held_val        = '0;
    in_count        = 0;
    out_count       = 0;
    frames          = 0;
    mismatch_errors = 0;
    other_errors    = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Start from idle and run random frames under random stalls
    wait_ready_in(20);
    feed_frame(1'b1);
    feed_frame(1'b1);

    // Three frames back to back against a mostly stalled output
    stall_mode = 2;
    feed_frame(1'b0);
    feed_frame(1'b0);
    feed_frame(1'b0);
    stall_mode = 1;
    wait_drained(5000);

    // Both banks full with the output held off
    stall_mode = 0;
    feed_frame(1'b1);
    feed_frame(1'b1);
    repeat (40) begin
      @(negedge clk);
      assert (!ready_in) else begin
        other_errors++;
        $display("ready_in went high while both banks were full");
      end
    end
    stall_mode = 1;
    wait_ready_in(2000);
    feed_frame(1'b1);
    wait_drained(5000);

    assert (in_count == frames * FRAME_PIXELS && out_count == frames * IMAGE_SIZE) else begin
      other_errors++;
      $display("Transfer count wrong: %0d pixels in, %0d pixels out over %0d frames",
               in_count, out_count, frames);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- src.f
logic/chan_acc_pkg.sv
logic/psum_mem_if.sv
logic/psum_buffer.sv
logic/psum_arbiter.sv
logic/channel_accumulator.sv
logic/result_drain.sv
logic/chan_acc_top.sv
sim/chan_acc_tb.sv
